/* grant_return.sv */
`timescale 1ns/1ps
`include "shmem_macros.svh"

module grant_return
(
	input	logic						clk,
	input	logic						reset,
	input	logic [`SM_NUM_BANKS-1:0]			grant_valid,
	input	shmem_pkg::core_id_t [`SM_NUM_BANKS-1:0]	grant_core,
	input	shmem_pkg::bank_id_t [`SM_NUM_CORES-1:0]	core_bank,
	input	shmem_pkg::mem_op_t [`SM_NUM_CORES-1:0]		core_op,
	input	shmem_pkg::word_t [`SM_NUM_BANKS-1:0]		bank_rdata,
	output	logic [`SM_NUM_CORES-1:0]			ready,
	output	logic [`SM_DATA_BUS_W-1:0]			rd_data
);

	import shmem_pkg::*;

	logic [`SM_NUM_CORES-1:0]		granted;	// won its bank this cycle
	logic [`SM_NUM_CORES-1:0]		is_read;
	logic [`SM_NUM_CORES-1:0]		served_read;
	bank_id_t [`SM_NUM_CORES-1:0]		served_bank;

	genvar c;

	generate
		for (c = 0; c < `SM_NUM_CORES; c = c + 1)
		begin : g_core
			// the winner of a bank is always one of its requesters
			assign granted[c] =
				grant_valid[core_bank[c]] &&
				(grant_core[core_bank[c]] == core_id_t'(c));
			assign is_read[c] = (core_op[c] == op_read);

			assign rd_data[c * `SM_DATA_W +: `SM_DATA_W] =
				served_read[c] ? bank_rdata[served_bank[c]] : '0;
		end
	endgenerate

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ready <= '0;
			served_read <= '0;
		end
		else
		begin
			ready <= granted;
			served_read <= granted & is_read;
		end
	end

	// only looked at while served_read is set
	always_ff @(posedge clk)
	begin
		served_bank <= core_bank;
	end

endmodule

/* mem_bank.sv */
`timescale 1ns/1ps
`include "shmem_macros.svh"

module mem_bank
(
	input	logic						clk,
	input	logic						reset,
	input	logic [`SM_NUM_CORES-1:0]			req_mask,
	input	logic [`SM_NUM_CORES-1:0][`SM_OFFSET_W-1:0]	core_offset,
	input	shmem_pkg::mem_op_t [`SM_NUM_CORES-1:0]		core_op,
	input	shmem_pkg::word_t [`SM_NUM_CORES-1:0]		core_wdata,
	output	logic						grant_valid,
	output	shmem_pkg::core_id_t				grant_core,
	output	shmem_pkg::word_t				bank_rdata
);

	import shmem_pkg::*;

	core_id_t			last_core;			// last granted core
	word_t				mem [`SM_BANK_WORDS];
	logic [`SM_OFFSET_W-1:0]	sel_offset;
	mem_op_t			sel_op;
	word_t				sel_wdata;
	logic				do_write;
	logic				do_read;

	rr_pick u_pick
	(
		.mask	(req_mask),
		.last	(last_core),
		.found	(grant_valid),
		.pick	(grant_core)
	);

	// winner's request, only meaningful with grant_valid
	assign sel_offset = core_offset[grant_core];
	assign sel_op = core_op[grant_core];
	assign sel_wdata = core_wdata[grant_core];

	assign do_write = grant_valid && (sel_op == op_write);
	assign do_read = grant_valid && (sel_op == op_read);

	// pointer starts on the last core so that core 0 wins first
	always_ff @(posedge clk)
	begin
		if (reset)
			last_core <= core_id_t'(`SM_NUM_CORES - 1);
		else if (grant_valid)
			last_core <= grant_core;
	end

	always_ff @(posedge clk)
	begin
		if (do_write)
			mem[sel_offset] <= sel_wdata;
	end

	// held until the next read grant on this bank
	always_ff @(posedge clk)
	begin
		if (do_read)
			bank_rdata <= mem[sel_offset];
	end

endmodule

/* project.f */
+incdir+.
shmem_pkg.sv
rr_pick.sv
req_decode.sv
mem_bank.sv
grant_return.sv
shared_mem.sv
tb_shared_mem.sv

/* req_decode.sv */
`timescale 1ns/1ps
`include "shmem_macros.svh"

module req_decode
(
	input	logic [`SM_ENABLE_BUS_W-1:0]				enable,
	input	logic [`SM_ADDR_BUS_W-1:0]				addr,
	input	logic [`SM_DATA_BUS_W-1:0]				wr_data,
	output	logic [`SM_NUM_BANKS-1:0][`SM_NUM_CORES-1:0]		bank_mask,
	output	shmem_pkg::bank_id_t [`SM_NUM_CORES-1:0]		core_bank,
	output	logic [`SM_NUM_CORES-1:0][`SM_OFFSET_W-1:0]		core_offset,
	output	shmem_pkg::mem_op_t [`SM_NUM_CORES-1:0]			core_op,
	output	shmem_pkg::word_t [`SM_NUM_CORES-1:0]			core_wdata
);

	import shmem_pkg::*;

	genvar c;
	genvar b;

	// per-core field split
	generate
		for (c = 0; c < `SM_NUM_CORES; c = c + 1)
		begin : g_core
			assign core_bank[c] =
				addr[c * `SM_ADDR_W + `SM_OFFSET_W +: `SM_BANK_ID_W];	// top bits
			assign core_offset[c] =
				addr[c * `SM_ADDR_W +: `SM_OFFSET_W];			// word in bank
			assign core_op[c] = mem_op_t'(enable[c * `SM_OP_W +: `SM_OP_W]);
			assign core_wdata[c] = wr_data[c * `SM_DATA_W +: `SM_DATA_W];
		end
	endgenerate

	// a core competes for a bank only with a live opcode aimed at it
	generate
		for (b = 0; b < `SM_NUM_BANKS; b = b + 1)
		begin : g_bank
			for (c = 0; c < `SM_NUM_CORES; c = c + 1)
			begin : g_req
				assign bank_mask[b][c] =
					(core_op[c] != op_idle) &&
					(core_bank[c] == bank_id_t'(b));
			end
		end
	endgenerate

endmodule

/* rr_pick.sv */
`timescale 1ns/1ps
`include "shmem_macros.svh"

module rr_pick
(
	input	logic [`SM_NUM_CORES-1:0]	mask,
	input	shmem_pkg::core_id_t		last,
	output	logic				found,
	output	shmem_pkg::core_id_t		pick
);

	// circular search, the slot after last has top priority
	always_comb
	begin
		int idx;

		found = 1'b0;
		pick = '0;
		for (int i = 1; i <= `SM_NUM_CORES; i++)
		begin
			idx = (int'(last) + i) % `SM_NUM_CORES;
			if (!found && mask[idx])
			begin
				found = 1'b1;
				pick = idx[`SM_CORE_ID_W-1:0];
			end
		end
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds the shared memory testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert \
	--top-module tb_shared_mem \
	--Mdir obj_dir \
	-o sim_shared_mem \
	-f project.f
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit $build_status
fi

./obj_dir/sim_shared_mem
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "Simulation failed with status $sim_status"
fi
exit $sim_status

/* shared_mem.sv */
`timescale 1ns/1ps
`include "shmem_macros.svh"

module shared_mem
(
	input	logic				clk,
	input	logic				reset,
	input	logic [`SM_ENABLE_BUS_W-1:0]	enable,
	input	logic [`SM_ADDR_BUS_W-1:0]	addr,
	input	logic [`SM_DATA_BUS_W-1:0]	wr_data,
	output	logic [`SM_DATA_BUS_W-1:0]	rd_data,
	output	logic [`SM_NUM_CORES-1:0]	ready
);

	import shmem_pkg::*;

	logic [`SM_NUM_BANKS-1:0][`SM_NUM_CORES-1:0]	bank_mask;
	bank_id_t [`SM_NUM_CORES-1:0]			core_bank;
	logic [`SM_NUM_CORES-1:0][`SM_OFFSET_W-1:0]	core_offset;
	mem_op_t [`SM_NUM_CORES-1:0]			core_op;
	word_t [`SM_NUM_CORES-1:0]			core_wdata;

	// one slice per bank instance
	wire logic [`SM_NUM_BANKS-1:0]			grant_valid;
	wire core_id_t [`SM_NUM_BANKS-1:0]		grant_core;
	wire word_t [`SM_NUM_BANKS-1:0]			bank_rdata;

	genvar b;

	req_decode u_decode
	(
		.enable		(enable),
		.addr		(addr),
		.wr_data	(wr_data),
		.bank_mask	(bank_mask),
		.core_bank	(core_bank),
		.core_offset	(core_offset),
		.core_op	(core_op),
		.core_wdata	(core_wdata)
	);

	generate
		for (b = 0; b < `SM_NUM_BANKS; b = b + 1)
		begin : g_bank
			mem_bank u_bank
			(
				.clk		(clk),
				.reset		(reset),
				.req_mask	(bank_mask[b]),
				.core_offset	(core_offset),
				.core_op	(core_op),
				.core_wdata	(core_wdata),
				.grant_valid	(grant_valid[b]),
				.grant_core	(grant_core[b]),
				.bank_rdata	(bank_rdata[b])
			);
		end
	endgenerate

	grant_return u_return
	(
		.clk		(clk),
		.reset		(reset),
		.grant_valid	(grant_valid),
		.grant_core	(grant_core),
		.core_bank	(core_bank),
		.core_op	(core_op),
		.bank_rdata	(bank_rdata),
		.ready		(ready),
		.rd_data	(rd_data)
	);

endmodule

/* shmem_macros.svh */
`ifndef SHMEM_MACROS_SVH
`define SHMEM_MACROS_SVH

// core and bank counts
`define SM_NUM_CORES	4
`define SM_NUM_BANKS	4

// storage per bank
`define SM_BANK_WORDS	16
`define SM_DATA_W	16

// index widths, log2 of the counts above
`define SM_CORE_ID_W	2
`define SM_BANK_ID_W	2
`define SM_OFFSET_W	4

// opcode field per core, write in bit 1 and read in bit 0
`define SM_OP_W		2

// bank number sits above the word offset
`define SM_ADDR_W	(`SM_BANK_ID_W + `SM_OFFSET_W)

// flat bus widths at the top level
`define SM_ENABLE_BUS_W	(`SM_NUM_CORES * `SM_OP_W)
`define SM_ADDR_BUS_W	(`SM_NUM_CORES * `SM_ADDR_W)
`define SM_DATA_BUS_W	(`SM_NUM_CORES * `SM_DATA_W)

`endif

/* shmem_pkg.sv */
`include "shmem_macros.svh"

package shmem_pkg;

	// encoding matches the enable field of each core
	typedef enum logic [`SM_OP_W-1:0]
	{
		op_idle  = 2'd0,
		op_read  = 2'd1,
		op_write = 2'd2
	} mem_op_t;

	// core index
	typedef logic [`SM_CORE_ID_W-1:0] core_id_t;

	// bank index
	typedef logic [`SM_BANK_ID_W-1:0] bank_id_t;

	// one memory word
	typedef logic [`SM_DATA_W-1:0] word_t;

endpackage

/* tb_shared_mem.sv */
`timescale 1ns/1ps
`include "shmem_macros.svh"

module tb_shared_mem;

	import shmem_pkg::*;

	typedef logic [`SM_ADDR_W-1:0] addr_t;

	logic				clk;
	logic				reset;
	logic [`SM_ENABLE_BUS_W-1:0]	enable;
	logic [`SM_ADDR_BUS_W-1:0]	addr;
	logic [`SM_DATA_BUS_W-1:0]	wr_data;
	logic [`SM_DATA_BUS_W-1:0]	rd_data;
	logic [`SM_NUM_CORES-1:0]	ready;

	logic [`SM_ENABLE_BUS_W-1:0]	held_en;	// request seen at the last edge
	logic [`SM_ADDR_BUS_W-1:0]	held_addr;
	logic [`SM_DATA_BUS_W-1:0]	held_wd;
	logic				mon_on;
	word_t				ref_mem [`SM_NUM_BANKS * `SM_BANK_WORDS];
	logic				ref_valid [`SM_NUM_BANKS * `SM_BANK_WORDS];

	shared_mem DUT
	(
		.clk		(clk),
		.reset		(reset),
		.enable		(enable),
		.addr		(addr),
		.wr_data	(wr_data),
		.rd_data	(rd_data),
		.ready		(ready)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic stop_run(string line);
		$display("%s", line);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
		stop_run($sformatf("** Error @ %0t: %s expected %0h actual %0h",
			$time, name, expected, actual));
	endtask

	// pattern depends on every address bit
	function automatic word_t fill_word(addr_t a);
		return {a, ~a, a[`SM_ADDR_W-1:2]};
	endfunction

	task automatic set_request(int c, mem_op_t op, addr_t a, word_t d);
		enable[c * `SM_OP_W +: `SM_OP_W] = op;
		addr[c * `SM_ADDR_W +: `SM_ADDR_W] = a;
		wr_data[c * `SM_DATA_W +: `SM_DATA_W] = d;
	endtask

	// hold one request until ready and then go idle
	task automatic access(int c, mem_op_t op, addr_t a, word_t d);
		int waited;

		set_request(c, op, a, d);
		waited = 0;
		@(negedge clk);
		while (!ready[c])
		begin
			if (waited >= 20)
				stop_run($sformatf("Core %0d waited more than 20 cycles for ready", c));
			waited++;
			@(negedge clk);
		end
		set_request(c, op_idle, a, d);
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		enable = '0;
		repeat (2)
		begin
			@(negedge clk);
			mon_on = 1'b1;
			assert (ready == '0) else report_mismatch("ready", 64'd0, 64'(ready));
			assert (rd_data == '0) else report_mismatch("rd_data", 64'd0, 64'(rd_data));
		end
		reset = 1'b0;
		@(negedge clk);
		assert (ready == '0) else report_mismatch("ready", 64'd0, 64'(ready));
		assert (rd_data == '0) else report_mismatch("rd_data", 64'd0, 64'(rd_data));
	endtask

	task automatic fill_bank(int c);
		addr_t a;

		for (int off = 0; off < `SM_BANK_WORDS; off++)
		begin
			a = {bank_id_t'(c), `SM_OFFSET_W'(off)};
			access(c, op_write, a, fill_word(a));
		end
	endtask

	// each core on its own bank so all four are served at the first edge
	task automatic check_parallel();
		addr_t a [`SM_NUM_CORES];

		for (int k = 0; k < `SM_NUM_CORES; k++)
		begin
			a[k] = {bank_id_t'((k + 1) % `SM_NUM_BANKS), `SM_OFFSET_W'($urandom)};
			set_request(k, op_write, a[k], word_t'($urandom));
		end
		@(negedge clk);
		assert (ready == '1) else report_mismatch("ready", 64'hf, 64'(ready));
		for (int k = 0; k < `SM_NUM_CORES; k++)
			set_request(k, op_read, a[k], '0);
		@(negedge clk);
		assert (ready == '1) else report_mismatch("ready", 64'hf, 64'(ready));
		for (int k = 0; k < `SM_NUM_CORES; k++)
			set_request(k, op_idle, a[k], '0);
	endtask

	task automatic run_random(int c, int count);
		for (int n = 0; n < count; n++)
		begin
			repeat ($urandom_range(0, 2)) @(negedge clk);
			access(c, mem_op_t'(`SM_OP_W'($urandom_range(1, 2))), addr_t'($urandom),
				word_t'($urandom));
		end
	endtask

	// core 2 leaves at its third grant and the rest leave near the end
	task automatic check_round_robin();
		int rr_order [17] = '{0, 1, 2, 3, 0, 1, 2, 3, 0, 1, 2, 3, 0, 1, 3, 0, 1};
		logic [`SM_NUM_CORES-1:0] exp_mask;
		int n;
		int waited;
		int k;

		apply_reset();
		for (int c = 0; c < `SM_NUM_CORES; c++)
			set_request(c, op_read, addr_t'(c), '0);	// all on bank 0
		n = 0;
		waited = 0;
		while (n < 17)
		begin
			@(negedge clk);
			k = rr_order[n];
			if (ready == '0)
			begin
				waited++;
				if (waited > 20)
					stop_run($sformatf("Core %0d waited more than 20 cycles for ready", k));
			end
			else
			begin
				waited = 0;
				exp_mask = '0;
				exp_mask[k] = 1'b1;
				assert (ready == exp_mask)
					else report_mismatch("ready", 64'(exp_mask), 64'(ready));
				if (n == 10 || n >= 14)
					set_request(k, op_idle, addr_t'(k), '0);
				n++;
			end
		end
	endtask

	always @(posedge clk)
	begin
		held_en <= enable;
		held_addr <= addr;
		held_wd <= wr_data;
	end

	// ready and rd_data answer the request held at the previous edge
	always @(negedge clk)
	begin
		mem_op_t op;
		addr_t a;
		word_t rd;
		word_t wd;

		if (mon_on)
		begin
			for (int c = 0; c < `SM_NUM_CORES; c++)
			begin
				op = mem_op_t'(held_en[c * `SM_OP_W +: `SM_OP_W]);
				a = held_addr[c * `SM_ADDR_W +: `SM_ADDR_W];
				wd = held_wd[c * `SM_DATA_W +: `SM_DATA_W];
				rd = rd_data[c * `SM_DATA_W +: `SM_DATA_W];
				if (ready[c])
				begin
					assert (op != op_idle)
						else stop_run($sformatf("Core %0d got ready without a request", c));
					if (op == op_read)
					begin
						if (ref_valid[a])
							assert (rd == ref_mem[a]) else report_mismatch(
								$sformatf("rd_data[%0d]", c), 64'(ref_mem[a]), 64'(rd));
					end
					else
					begin
						assert (rd == '0) else report_mismatch(
							$sformatf("rd_data[%0d]", c), 64'd0, 64'(rd));
						ref_mem[a] = wd;
						ref_valid[a] = 1'b1;
					end
				end
				else
					assert (rd == '0) else report_mismatch(
						$sformatf("rd_data[%0d]", c), 64'd0, 64'(rd));
			end
		end
	end

	assert property (@(posedge clk) disable iff (!mon_on) $past(reset) |-> ready == '0)
		else report_mismatch("ready", 64'd0, 64'(ready));
	assert property (@(posedge clk) disable iff (!mon_on) $past(reset) |-> rd_data == '0)
		else report_mismatch("rd_data", 64'd0, 64'(rd_data));

	initial
	begin
		void'($urandom(48498));
		reset = 1'b1;
		enable = '0;
		addr = '0;
		wr_data = '0;
		mon_on = 1'b0;
		for (int i = 0; i < `SM_NUM_BANKS * `SM_BANK_WORDS; i++)
			ref_valid[i] = 1'b0;

		apply_reset();
		fork
			fill_bank(0);
			fill_bank(1);
			fill_bank(2);
			fill_bank(3);
		join
		check_parallel();
		fork
			run_random(0, 40);
			run_random(1, 40);
			run_random(2, 40);
			run_random(3, 40);
		join
		check_round_robin();
		repeat (2) @(negedge clk);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule
